// ==== include/rr_settings.svh ====
`ifndef RR_SETTINGS_SVH
`define RR_SETTINGS_SVH

////////////////////////////////////////
// host channels
////////////////////////////////////////

// request address, covers the register file and some out of range space
`define RR_ADDR_W 8
// data on both the request and the response
`define RR_DATA_W 32

////////////////////////////////////////
// logging path
////////////////////////////////////////

// per channel sequence number, wraps silently
`define RR_SEQ_W 16
// trace buffer entries
`define RR_TRACE_DEPTH 16
// fill level has to reach the full depth
`define RR_LEVEL_W ($clog2(`RR_TRACE_DEPTH + 1))
// wider of the two beats, 1 + addr + data for a request
`define RR_PAYLOAD_W 41

// registers in the demo user logic
`define RR_REG_CNT 16

`endif

// ==== src/rr_pkg.sv ====
`default_nettype none

`include "rr_settings.svh"

package rr_pkg;

  // host request opcode
  typedef enum logic {
    RR_OP_READ  = 1'b0,
    RR_OP_WRITE = 1'b1
  } rr_op_e;

  // source channel of a log entry
  typedef enum logic {
    RR_CHAN_REQ = 1'b0,
    RR_CHAN_RSP = 1'b1
  } rr_chan_e;

  // request beat, op sits in the msb
  typedef struct packed {
    rr_op_e                op;
    logic [`RR_ADDR_W-1:0] addr;
    logic [`RR_DATA_W-1:0] data;
  } rr_req_t;

  // response beat
  // err is set for an address past the register file
  typedef struct packed {
    logic                  err;
    logic [`RR_DATA_W-1:0] data;
  } rr_rsp_t;

  // log payload
  // requests fill it completely, responses sit in the low bits
  typedef logic [`RR_PAYLOAD_W-1:0] rr_payload_t;

endpackage

`default_nettype wire

// ==== src/rr_log_if.sv ====
`default_nettype none

`include "rr_settings.svh"

// one log stream, valid/ready handshake
// a transfer happens on an edge with valid and ready both high
interface rr_log_if;

  logic                    valid;
  logic                    ready;
  // channel id, same encoding as rr_chan_e
  logic                    chan;
  logic [`RR_SEQ_W-1:0]    seq;
  logic [`RR_PAYLOAD_W-1:0] payload;

  // producer of entries, valid never waits on ready
  modport source (
    output valid, chan, seq, payload,
    input  ready
  );

  modport sink (
    input  valid, chan, seq, payload,
    output ready
  );

  // passive observer
  modport monitor (
    input valid, ready, chan, seq, payload
  );

endinterface

`default_nettype wire

// ==== src/rr_channel_recorder.sv ====
`default_nettype none

`include "rr_settings.svh"

module rr_channel_recorder
  import rr_pkg::*;
#(
  parameter int unsigned PAYLOAD_W = `RR_PAYLOAD_W,
  parameter rr_chan_e    CHAN      = RR_CHAN_REQ
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 record_en,
  // upstream side
  input  logic                 in_valid,
  output logic                 in_ready,
  input  logic [PAYLOAD_W-1:0] in_payload,
  // downstream side
  output logic                 out_valid,
  input  logic                 out_ready,
  output logic [PAYLOAD_W-1:0] out_payload,
  // log entries
  rr_log_if.source             log
);

  logic                 path_ok;
  logic                 log_fire;
  logic [`RR_SEQ_W-1:0] seq_q;
  rr_payload_t          log_payload;

  ////////////////////////////////////////
  // channel pass-through
  ////////////////////////////////////////

  // with recording on the log must take the entry in the same cycle
  assign path_ok = !record_en || log.ready;

  assign out_valid   = in_valid && path_ok;
  assign in_ready    = out_ready && path_ok;
  assign out_payload = in_payload;

  ////////////////////////////////////////
  // log side
  ////////////////////////////////////////

  // valid depends only on the channel, never on log ready
  assign log.valid = record_en && in_valid && out_ready;
  assign log_fire  = log.valid && log.ready;

  // zero extend the beat into the common payload
  always_comb begin
    log_payload                = '0;
    log_payload[PAYLOAD_W-1:0] = in_payload;
  end

  assign log.payload = log_payload;
  assign log.chan    = CHAN;
  assign log.seq     = seq_q;

  // counts recorded beats only
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      seq_q <= '0;
    end else if (log_fire) begin
      seq_q <= seq_q + 1'b1;
    end
  end

  // an entry leaves only for a beat that crossed the recorder while recording
  assert property (@(posedge clk) disable iff (!rst_n)
    log_fire |-> (record_en && in_valid && in_ready && out_valid))
  else $error("log entry without a recorded beat, chan %0d", CHAN);

endmodule

`default_nettype wire

// ==== src/rr_log_arbiter.sv ====
`default_nettype none

`include "rr_settings.svh"

module rr_log_arbiter
  import rr_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  rr_log_if.sink   in_a,
  rr_log_if.sink   in_b,
  rr_log_if.source out
);

  logic                 can_load;
  logic                 take_a;
  logic                 take_b;
  logic                 contended;
  // a wins the next contended grant
  logic                 prio_a_q;
  logic                 out_valid_q;
  rr_chan_e             out_chan_q;
  logic [`RR_SEQ_W-1:0] out_seq_q;
  rr_payload_t          out_payload_q;

  ////////////////////////////////////////
  // grant
  ////////////////////////////////////////

  // register empty or draining this cycle
  assign can_load  = !out_valid_q || out.ready;
  assign contended = in_a.valid && in_b.valid;

  // readies use registered state and the other side's valid only
  assign in_a.ready = can_load && (!in_b.valid || prio_a_q);
  assign in_b.ready = can_load && (!in_a.valid || !prio_a_q);

  assign take_a = in_a.valid && in_a.ready;
  assign take_b = in_b.valid && in_b.ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      prio_a_q    <= 1'b1;
      out_valid_q <= 1'b0;
    end else begin
      // hand priority over after each contended grant
      if (contended && can_load) begin
        prio_a_q <= !prio_a_q;
      end
      if (take_a || take_b) begin
        out_valid_q <= 1'b1;
      end else if (out.ready) begin
        out_valid_q <= 1'b0;
      end
    end
  end

  ////////////////////////////////////////
  // output register
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (take_a) begin
      out_chan_q    <= rr_chan_e'(in_a.chan);
      out_seq_q     <= in_a.seq;
      out_payload_q <= in_a.payload;
    end else if (take_b) begin
      out_chan_q    <= rr_chan_e'(in_b.chan);
      out_seq_q     <= in_b.seq;
      out_payload_q <= in_b.payload;
    end
  end

  assign out.valid   = out_valid_q;
  assign out.chan    = out_chan_q;
  assign out.seq     = out_seq_q;
  assign out.payload = out_payload_q;

  // one entry per edge into the single register
  assert property (@(posedge clk) disable iff (!rst_n) !(take_a && take_b))
  else $error("arbiter accepted both log inputs");

endmodule

`default_nettype wire

// ==== src/rr_trace_buffer.sv ====
`default_nettype none

`include "rr_settings.svh"

module rr_trace_buffer
  import rr_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst_n,
  rr_log_if.sink                 in,
  // host drain port
  output logic                   trace_valid,
  input  logic                   trace_ready,
  output rr_chan_e               trace_chan,
  output logic [`RR_SEQ_W-1:0]   trace_seq,
  output rr_payload_t            trace_payload,
  output logic [`RR_LEVEL_W-1:0] trace_level
);

  localparam int unsigned DEPTH = `RR_TRACE_DEPTH;
  localparam int unsigned PTR_W = $clog2(DEPTH);

  // entry storage, no reset
  rr_chan_e             chan_mem    [DEPTH];
  logic [`RR_SEQ_W-1:0] seq_mem     [DEPTH];
  rr_payload_t          payload_mem [DEPTH];

  logic [PTR_W-1:0]       wr_ptr_q;
  logic [PTR_W-1:0]       rd_ptr_q;
  logic [`RR_LEVEL_W-1:0] level_q;
  logic                   push;
  logic                   pop;

  // circular step, also fine for a depth that is not a power of two
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    logic [PTR_W-1:0] nxt;
    nxt = (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    return nxt;
  endfunction

  ////////////////////////////////////////
  // handshakes
  ////////////////////////////////////////

  assign in.ready    = (level_q != DEPTH);
  assign trace_valid = (level_q != '0);
  assign push        = in.valid && in.ready;
  assign pop         = trace_valid && trace_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      level_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      // occupancy only moves when exactly one side fires
      if (push && !pop) begin
        level_q <= level_q + 1'b1;
      end else if (pop && !push) begin
        level_q <= level_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      chan_mem[wr_ptr_q]    <= rr_chan_e'(in.chan);
      seq_mem[wr_ptr_q]     <= in.seq;
      payload_mem[wr_ptr_q] <= in.payload;
    end
  end

  ////////////////////////////////////////
  // read side
  ////////////////////////////////////////

  assign trace_chan    = chan_mem[rd_ptr_q];
  assign trace_seq     = seq_mem[rd_ptr_q];
  assign trace_payload = payload_mem[rd_ptr_q];
  assign trace_level   = level_q;

  // the arbiter must see ready low once the last slot is taken
  assert property (@(posedge clk) disable iff (!rst_n)
    push |-> (level_q < DEPTH))
  else $error("trace buffer push while full, level %0d", level_q);

endmodule

`default_nettype wire

// ==== src/rr_demo_cl.sv ====
`default_nettype none

`include "rr_settings.svh"

module rr_demo_cl
  import rr_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  // request in
  input  logic    req_valid,
  output logic    req_ready,
  input  rr_req_t req,
  // response out
  output logic    rsp_valid,
  input  logic    rsp_ready,
  output rr_rsp_t rsp
);

  localparam int unsigned IDX_W = $clog2(`RR_REG_CNT);

  logic [`RR_DATA_W-1:0] regs_q [`RR_REG_CNT];
  logic                  rsp_valid_q;
  rr_rsp_t               rsp_q;
  logic                  req_fire;
  logic                  rsp_fire;
  logic                  in_range;
  logic [IDX_W-1:0]      idx;

  // one request in flight, next one waits for the response to leave
  assign req_ready = !rsp_valid_q;
  assign req_fire  = req_valid && req_ready;
  assign rsp_fire  = rsp_valid_q && rsp_ready;

  assign in_range = (req.addr < `RR_REG_CNT);
  assign idx      = req.addr[IDX_W-1:0];

  ////////////////////////////////////////
  // register file
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `RR_REG_CNT; i++) begin
        regs_q[i] <= '0;
      end
    end else if (req_fire && in_range && (req.op == RR_OP_WRITE)) begin
      regs_q[idx] <= req.data;
    end
  end

  ////////////////////////////////////////
  // response
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rsp_valid_q <= 1'b0;
    end else if (req_fire) begin
      rsp_valid_q <= 1'b1;
    end else if (rsp_fire) begin
      rsp_valid_q <= 1'b0;
    end
  end

  // held until accepted since req_ready blocks a new load
  always_ff @(posedge clk) begin
    if (req_fire) begin
      if (!in_range) begin
        rsp_q.err  <= 1'b1;
        rsp_q.data <= '0;
      end else begin
        rsp_q.err  <= 1'b0;
        // a write echoes its data, a read returns the old value
        rsp_q.data <= (req.op == RR_OP_WRITE) ? req.data : regs_q[idx];
      end
    end
  end

  assign rsp_valid = rsp_valid_q;
  assign rsp       = rsp_q;

  assert property (@(posedge clk) disable iff (!rst_n)
    (rsp_valid && !rsp_ready) |=> (rsp_valid && $stable(rsp)))
  else $error("demo response changed while stalled");

endmodule

`default_nettype wire

// ==== src/rr_wrapper.sv ====
`default_nettype none

`include "rr_settings.svh"

//  host req ==> [req recorder] ==> rr_demo_cl ==> [rsp recorder] ==> host rsp
//                    |                                  |
//                 req_log                            rsp_log
//                    +---------> rr_log_arbiter <-------+
//                                      |
//                                 merged_log
//                                      |
//                               rr_trace_buffer ==> host trace port
module rr_wrapper
  import rr_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   record_en,
  // host request
  input  logic                   req_valid,
  output logic                   req_ready,
  input  rr_op_e                 req_op,
  input  logic [`RR_ADDR_W-1:0]  req_addr,
  input  logic [`RR_DATA_W-1:0]  req_data,
  // host response
  output logic                   rsp_valid,
  input  logic                   rsp_ready,
  output logic [`RR_DATA_W-1:0]  rsp_data,
  output logic                   rsp_err,
  // trace drain
  output logic                   trace_valid,
  input  logic                   trace_ready,
  output rr_chan_e               trace_chan,
  output logic [`RR_SEQ_W-1:0]   trace_seq,
  output rr_payload_t            trace_payload,
  output logic [`RR_LEVEL_W-1:0] trace_level
);

  rr_req_t host_req;
  rr_req_t cl_req;
  logic    cl_req_valid;
  logic    cl_req_ready;
  rr_rsp_t cl_rsp;
  logic    cl_rsp_valid;
  logic    cl_rsp_ready;
  rr_rsp_t host_rsp;

  rr_log_if req_log ();
  rr_log_if rsp_log ();
  rr_log_if merged_log ();

  assign host_req = '{op: req_op, addr: req_addr, data: req_data};
  assign rsp_data = host_rsp.data;
  assign rsp_err  = host_rsp.err;

  ////////////////////////////////////////
  // recorded channels and user logic
  ////////////////////////////////////////

  rr_channel_recorder #(
    .PAYLOAD_W ($bits(rr_req_t)),
    .CHAN      (RR_CHAN_REQ)
  ) req_recorder (
    .clk, .rst_n, .record_en,
    .in_valid    (req_valid),
    .in_ready    (req_ready),
    .in_payload  (host_req),
    .out_valid   (cl_req_valid),
    .out_ready   (cl_req_ready),
    .out_payload (cl_req),
    .log         (req_log)
  );

  rr_demo_cl cl (
    .clk, .rst_n,
    .req_valid (cl_req_valid),
    .req_ready (cl_req_ready),
    .req       (cl_req),
    .rsp_valid (cl_rsp_valid),
    .rsp_ready (cl_rsp_ready),
    .rsp       (cl_rsp)
  );

  rr_channel_recorder #(
    .PAYLOAD_W ($bits(rr_rsp_t)),
    .CHAN      (RR_CHAN_RSP)
  ) rsp_recorder (
    .clk, .rst_n, .record_en,
    .in_valid    (cl_rsp_valid),
    .in_ready    (cl_rsp_ready),
    .in_payload  (cl_rsp),
    .out_valid   (rsp_valid),
    .out_ready   (rsp_ready),
    .out_payload (host_rsp),
    .log         (rsp_log)
  );

  ////////////////////////////////////////
  // log merge and trace storage
  ////////////////////////////////////////

  // requests on input a, a request entry always leads its response
  rr_log_arbiter log_arbiter (
    .clk, .rst_n,
    .in_a (req_log),
    .in_b (rsp_log),
    .out  (merged_log)
  );

  rr_trace_buffer trace_buffer (
    .clk, .rst_n,
    .in            (merged_log),
    .trace_valid,
    .trace_ready,
    .trace_chan,
    .trace_seq,
    .trace_payload,
    .trace_level
  );

endmodule

`default_nettype wire

// ==== tb/rr_trace_checker.sv ====
`default_nettype none

`include "rr_settings.svh"

module rr_trace_checker
  import rr_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   record_en,
  input  logic                   req_valid,
  input  logic                   req_ready,
  input  rr_op_e                 req_op,
  input  logic [`RR_ADDR_W-1:0]  req_addr,
  input  logic [`RR_DATA_W-1:0]  req_data,
  input  logic                   rsp_valid,
  input  logic                   rsp_ready,
  input  logic [`RR_DATA_W-1:0]  rsp_data,
  input  logic                   rsp_err,
  input  logic                   trace_valid,
  input  logic                   trace_ready,
  input  rr_chan_e               trace_chan,
  input  logic [`RR_SEQ_W-1:0]   trace_seq,
  input  rr_payload_t            trace_payload,
  input  logic [`RR_LEVEL_W-1:0] trace_level,
  output int                     errors
);

  timeunit 1ns;
  timeprecision 1ns;

  // register file model, follows every accepted request
  logic [`RR_DATA_W-1:0]  model [`RR_REG_CNT];
  // one expected response per accepted request
  rr_rsp_t                exp_rsp_q [$];
  // recorded beats still waiting for their trace entry
  rr_payload_t            req_log_q [$];
  rr_payload_t            rsp_log_q [$];
  int                     req_drained;
  int                     rsp_drained;
  int                     rsp_checked;
  // first value shown by a response that had to wait
  logic                   rsp_held;
  rr_rsp_t                rsp_first;
  logic                   prev_trace_ready;
  logic [`RR_LEVEL_W-1:0] prev_level;
  logic                   saw_full;

  // answer the register file gives for one request
  function automatic rr_rsp_t rr_expect_rsp(input rr_op_e                op,
                                            input logic [`RR_ADDR_W-1:0] addr,
                                            input logic [`RR_DATA_W-1:0] data);
    rr_rsp_t rsp;
    rsp.err  = 1'b0;
    rsp.data = '0;
    if (addr >= `RR_REG_CNT) begin
      rsp.err = 1'b1;
    end else if (op == RR_OP_WRITE) begin
      rsp.data = data;
    end else begin
      rsp.data = model[addr];
    end
    return rsp;
  endfunction

  task automatic value_mismatch(input string name, input logic [63:0] expected,
                                input logic [63:0] actual);
    errors++;
    $display("[ERROR] %s: expected %0h, got %0h at %0t", name, expected, actual, $time);
  endtask

  task automatic note_failure(input string what);
    errors++;
    $display("error at %0t: %s", $time, what);
  endtask

  ////////////////////////////////////////
  // per edge sampling
  ////////////////////////////////////////

  always @(posedge clk) begin : sample
    rr_rsp_t     rsp_now;
    rr_rsp_t     exp;
    rr_payload_t beat;
    if (!rst_n) begin
      for (int i = 0; i < `RR_REG_CNT; i++) begin
        model[i] = '0;
      end
      exp_rsp_q.delete();
      req_log_q.delete();
      rsp_log_q.delete();
      req_drained      = 0;
      rsp_drained      = 0;
      rsp_checked      = 0;
      rsp_held         = 1'b0;
      prev_trace_ready = 1'b1;
      prev_level       = '0;
      saw_full         = 1'b0;
      errors           = 0;
    end else begin
      rsp_now.err  = rsp_err;
      rsp_now.data = rsp_data;

      // accepted request, expected answer taken before the model moves
      if (req_valid && req_ready) begin
        exp_rsp_q.push_back(rr_expect_rsp(req_op, req_addr, req_data));
        if (req_op == RR_OP_WRITE && req_addr < `RR_REG_CNT) begin
          model[req_addr] = req_data;
        end
        if (record_en) begin
          req_log_q.push_back({req_op, req_addr, req_data});
        end
      end

      // response, held value must survive a stall
      if (rsp_valid) begin
        if (!rsp_held) begin
          rsp_first = rsp_now;
        end
        if (rsp_ready) begin
          if (rsp_now.data !== rsp_first.data) begin
            value_mismatch("rsp_data (held)", rsp_first.data, rsp_now.data);
          end
          if (rsp_now.err !== rsp_first.err) begin
            value_mismatch("rsp_err (held)", rsp_first.err, rsp_now.err);
          end
          if (exp_rsp_q.size() == 0) begin
            note_failure("response accepted with no request outstanding");
          end else begin
            exp = exp_rsp_q.pop_front();
            if (rsp_now.data !== exp.data) value_mismatch("rsp_data", exp.data, rsp_now.data);
            if (rsp_now.err !== exp.err) value_mismatch("rsp_err", exp.err, rsp_now.err);
            rsp_checked++;
          end
          // response beats sit zero extended in the payload
          if (record_en) begin
            beat                         = '0;
            beat[$bits(rr_rsp_t)-1:0] = rsp_now;
            rsp_log_q.push_back(beat);
          end
          rsp_held = 1'b0;
        end else begin
          rsp_held = 1'b1;
        end
      end

      ////////////////////////////////////////
      // trace drain
      ////////////////////////////////////////

      if (trace_valid && trace_ready) begin
        if (trace_chan == RR_CHAN_REQ) begin
          if (req_log_q.size() == 0) begin
            note_failure("request trace entry with no recorded request beat");
          end else begin
            beat = req_log_q.pop_front();
            if (trace_payload !== beat) value_mismatch("trace_payload", beat, trace_payload);
            if (trace_seq !== req_drained[`RR_SEQ_W-1:0]) begin
              value_mismatch("trace_seq", req_drained, trace_seq);
            end
            req_drained++;
          end
        end else begin
          // its own request entry has to be out already
          if (rsp_drained >= req_drained) begin
            note_failure("response trace entry ahead of its request entry");
          end
          if (rsp_log_q.size() == 0) begin
            note_failure("response trace entry with no recorded response beat");
          end else begin
            beat = rsp_log_q.pop_front();
            if (trace_payload !== beat) value_mismatch("trace_payload", beat, trace_payload);
            if (trace_seq !== rsp_drained[`RR_SEQ_W-1:0]) begin
              value_mismatch("trace_seq", rsp_drained, trace_seq);
            end
            rsp_drained++;
          end
        end
      end

      // fill level never passes the depth and never falls without a drain
      if (trace_level > `RR_TRACE_DEPTH) begin
        value_mismatch("trace_level (max)", `RR_TRACE_DEPTH, trace_level);
      end
      if (!prev_trace_ready && trace_level < prev_level) begin
        value_mismatch("trace_level (no drain)", prev_level, trace_level);
      end
      if (trace_level == `RR_TRACE_DEPTH) begin
        saw_full = 1'b1;
      end
      prev_trace_ready = trace_ready;
      prev_level       = trace_level;
    end
  end

  // leftovers mean a beat got lost somewhere
  task automatic final_check();
    if (exp_rsp_q.size() != 0) begin
      note_failure($sformatf("%0d requests never got a response", exp_rsp_q.size()));
    end
    if (req_log_q.size() != 0) begin
      note_failure($sformatf("%0d recorded requests missing from the trace", req_log_q.size()));
    end
    if (rsp_log_q.size() != 0) begin
      note_failure($sformatf("%0d recorded responses missing from the trace", rsp_log_q.size()));
    end
    if (!saw_full) begin
      note_failure("trace buffer never reached full");
    end
    $display("checked %0d responses, %0d request entries, %0d response entries, %0d errors",
             rsp_checked, req_drained, rsp_drained, errors);
  endtask

endmodule

`default_nettype wire

// ==== tb/rr_wrapper_tb.sv ====
`default_nettype none

`include "rr_settings.svh"

module rr_wrapper_tb
  import rr_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ns;

  localparam int unsigned DIRECTED_REQS = 10;
  localparam int unsigned RANGE_REQS    = 5;
  localparam int unsigned RANDOM_REQS   = 60;
  localparam int unsigned QUIET_REQS    = 15;
  localparam int unsigned RESUME_REQS   = 5;
  localparam int unsigned STALL_REQS    = 12;
  localparam int unsigned TOTAL_REQS    = DIRECTED_REQS + RANGE_REQS + RANDOM_REQS
                                          + QUIET_REQS + RESUME_REQS + STALL_REQS;
  // slow drains and the full stall fit well inside this
  localparam int unsigned CYCLE_LIMIT   = 20 * TOTAL_REQS + 200;

  logic                   clk = 1'b0;
  logic                   rst_n;
  logic                   record_en;
  logic                   req_valid;
  logic                   req_ready;
  rr_op_e                 req_op;
  logic [`RR_ADDR_W-1:0]  req_addr;
  logic [`RR_DATA_W-1:0]  req_data;
  logic                   rsp_valid;
  logic                   rsp_ready;
  logic [`RR_DATA_W-1:0]  rsp_data;
  logic                   rsp_err;
  logic                   trace_valid;
  logic                   trace_ready;
  rr_chan_e               trace_chan;
  logic [`RR_SEQ_W-1:0]   trace_seq;
  rr_payload_t            trace_payload;
  logic [`RR_LEVEL_W-1:0] trace_level;
  // rsp_ready mode with 0 always ready and 1 random
  int                     rsp_mode;
  // trace_ready mode is 0 always ready or 1 random or 2 held low
  int                     trace_mode;
  int                     cycles;
  int                     errors;

  rr_wrapper DUT (
    .clk, .rst_n, .record_en,
    .req_valid, .req_ready, .req_op, .req_addr, .req_data,
    .rsp_valid, .rsp_ready, .rsp_data, .rsp_err,
    .trace_valid, .trace_ready, .trace_chan, .trace_seq, .trace_payload, .trace_level
  );

  rr_trace_checker chk (
    .clk, .rst_n, .record_en,
    .req_valid, .req_ready, .req_op, .req_addr, .req_data,
    .rsp_valid, .rsp_ready, .rsp_data, .rsp_err,
    .trace_valid, .trace_ready, .trace_chan, .trace_seq, .trace_payload, .trace_level,
    .errors
  );

  initial begin
    forever #50 clk = ~clk;
  end

  // ready lines move on the falling edge only
  always @(negedge clk) begin
    rsp_ready = (rsp_mode == 0) || ($urandom_range(3, 0) != 0);
    case (trace_mode)
      0:       trace_ready = 1'b1;
      1:       trace_ready = ($urandom_range(1, 0) == 1);
      default: trace_ready = 1'b0;
    endcase
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > CYCLE_LIMIT) begin
      $display("timeout: run passed %0d cycles with %0d errors so far", CYCLE_LIMIT, errors);
      $display(">>> FAIL");
      $finish;
    end
  end

  ////////////////////////////////////////
  // host side helpers
  ////////////////////////////////////////

  // starts and ends on a falling edge
  task automatic send_req(input rr_op_e op, input int unsigned addr,
                          input logic [`RR_DATA_W-1:0] data);
    req_valid = 1'b1;
    req_op    = op;
    req_addr  = addr[`RR_ADDR_W-1:0];
    req_data  = data;
    do begin
      @(posedge clk);
    end while (!req_ready);
    @(negedge clk);
    req_valid = 1'b0;
  endtask

  task automatic send_random();
    rr_op_e      op;
    int unsigned addr;
    op   = ($urandom_range(1, 0) == 1) ? RR_OP_WRITE : RR_OP_READ;
    // a few addresses land past the register file
    addr = $urandom_range(19, 0);
    send_req(op, addr, $urandom);
    repeat ($urandom_range(2, 0)) @(negedge clk);
  endtask

  // demo logic holds no response and the log path is open
  task automatic wait_idle();
    do begin
      @(posedge clk);
    end while (!req_ready);
    @(negedge clk);
  endtask

  task automatic set_modes(input int rsp_m, input int trace_m);
    @(posedge clk);
    rsp_mode   = rsp_m;
    trace_mode = trace_m;
    @(negedge clk);
  endtask

  task automatic wait_drained();
    wait_idle();
    repeat (4) @(posedge clk);
    while (trace_level != 0) @(posedge clk);
    @(negedge clk);
  endtask

  initial begin
    void'($urandom(32'h7d15));
    rst_n       = 1'b0;
    record_en   = 1'b1;
    req_valid   = 1'b0;
    req_op      = RR_OP_READ;
    req_addr    = '0;
    req_data    = '0;
    rsp_ready   = 1'b1;
    trace_ready = 1'b1;
    rsp_mode    = 0;
    trace_mode  = 0;
    repeat (2) @(negedge clk);
    rst_n = 1'b1;

    // directed writes and read back
    // register 9 is never written
    for (int i = 0; i < 4; i++) begin
      send_req(RR_OP_WRITE, i, 32'ha5a5_0000 + i * 32'h111);
    end
    for (int i = 0; i < 4; i++) begin
      send_req(RR_OP_READ, i, '0);
    end
    send_req(RR_OP_READ, 9, '0);
    send_req(RR_OP_WRITE, 15, 32'hdead_beef);

    // out of range accesses leave register 0 untouched
    send_req(RR_OP_WRITE, 16, 32'h0bad_0bad);
    send_req(RR_OP_WRITE, 255, 32'hffff_ffff);
    send_req(RR_OP_READ, 16, '0);
    send_req(RR_OP_READ, 200, '0);
    send_req(RR_OP_READ, 0, '0);

    set_modes(1, 1);
    repeat (RANDOM_REQS) send_random();

    // quiet stretch with recording off
    // sequence numbers pick up afterwards
    wait_idle();
    record_en = 1'b0;
    repeat (QUIET_REQS) send_random();
    wait_idle();
    record_en = 1'b1;
    repeat (RESUME_REQS) send_random();

    ////////////////////////////////////////
    // trace stall
    ////////////////////////////////////////

    wait_idle();
    set_modes(0, 2);
    fork
      repeat (STALL_REQS) send_random();
      begin
        while (trace_level != `RR_TRACE_DEPTH) @(posedge clk);
        repeat (20) @(posedge clk);
        trace_mode = 0;
      end
    join

    wait_drained();
    chk.final_check();
    if (chk.errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+include
src/rr_pkg.sv
src/rr_log_if.sv
src/rr_channel_recorder.sv
src/rr_log_arbiter.sv
src/rr_trace_buffer.sv
src/rr_demo_cl.sv
src/rr_wrapper.sv
tb/rr_trace_checker.sv
tb/rr_wrapper_tb.sv

// ==== Bender.yml ====
package:
  name: rr_logging

sources:
  - include_dirs:
      - include
    files:
      - src/rr_pkg.sv
      - src/rr_log_if.sv
      - src/rr_channel_recorder.sv
      - src/rr_log_arbiter.sv
      - src/rr_trace_buffer.sv
      - src/rr_demo_cl.sv
      - src/rr_wrapper.sv

  - target: test
    include_dirs:
      - include
    files:
      - tb/rr_trace_checker.sv
      - tb/rr_wrapper_tb.sv
